//--- hw/iCacheData.sv
`timescale 1ns/1ps

module iCacheData
    import iCachePkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      readEn,
    input  logic [DATA_ADDR_BITS-1:0] lookupAddr,
    input  logic                      wrEn,
    input  logic [DATA_ADDR_BITS-1:0] wrAddr,
    input  logic [31:0]               wrData,
    output logic                      instrValid,
    output logic [31:0]               instr
);

    logic [31:0] mem [NUM_LINES * WORDS_PER_LINE];

    // fill port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // fetch port, one cycle latency
    always_ff @(posedge clk) begin
        if (readEn) begin
            instr <= mem[lookupAddr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            instrValid <= 1'b0;
        end else begin
            instrValid <= readEn;
        end
    end

    // fills only run while the table is busy, so reads and writes never overlap
    assert property (@(posedge clk) disable iff (rst)
        !(wrEn && readEn));

endmodule

//--- hw/iCachePkg.sv
package iCachePkg;

    // cache geometry, all sizes in bytes are given as log2
    localparam int CACHE_SIZE_E = 10;
    localparam int CLSIZE_E = 6;
    localparam int ASSOC = 2;

    localparam int NUM_LINES = 1 << (CACHE_SIZE_E - CLSIZE_E);
    localparam int NUM_SETS = NUM_LINES / ASSOC;
    localparam int SET_BITS = $clog2(NUM_SETS);
    localparam int WAY_BITS = $clog2(ASSOC);
    localparam int WORDS_PER_LINE = 1 << (CLSIZE_E - 2);

    // pc bits above set index and line offset
    localparam int TAG_BITS = 32 - CLSIZE_E - SET_BITS;

    // word address into the data array as {way, set, word}
    localparam int DATA_ADDR_BITS = WAY_BITS + SET_BITS + CLSIZE_E - 2;

    // command from the tag table to the line-fill controller
    typedef enum logic {
        MEMC_NONE,
        MEMC_FILL
    } MemcCmd;

    // one tag slot per set and way
    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic                valid;
    } TagEntry;

endpackage

//--- hw/iCacheTable.sv
`timescale 1ns/1ps

module iCacheTable
    import iCachePkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fetchValid,
    input  logic [31:0]               fetchPc,
    output logic                      fetchStall,
    output logic [DATA_ADDR_BITS-1:0] lookupAddr,
    output logic                      readEn,
    memcIf.client                     memc
);

    typedef enum logic [1:0] {
        IDLE,
        LOAD_RQ,
        LOAD_ACTIVE,
        CLEAN
    } TableState;

    TableState state;

    TagEntry             tagTable [NUM_SETS][ASSOC];
    logic [WAY_BITS-1:0] victim [NUM_SETS];

    logic [SET_BITS-1:0] setIdx;
    logic [TAG_BITS-1:0] pcTag;
    logic                hit;
    logic [WAY_BITS-1:0] hitWay;

    logic [SET_BITS-1:0] cleanIdx;
    logic [SET_BITS-1:0] loadSet;
    logic [WAY_BITS-1:0] loadWay;

    assign setIdx = fetchPc[CLSIZE_E +: SET_BITS];
    assign pcTag = fetchPc[31 -: TAG_BITS];

    always_comb begin
        hit = 1'b0;
        hitWay = '0;
        for (int w = 0; w < ASSOC; w++) begin
            if (tagTable[setIdx][w].valid && tagTable[setIdx][w].tag == pcTag) begin
                hit = 1'b1;
                hitWay = WAY_BITS'(w);
            end
        end
    end

    // lookups are only served once the sweep and any fill are done
    assign fetchStall = fetchValid && (!hit || state != IDLE);
    assign readEn = fetchValid && hit && state == IDLE;
    assign lookupAddr = {hitWay, setIdx, fetchPc[CLSIZE_E-1:2]};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CLEAN;
            cleanIdx <= '0;
            memc.cmd <= MEMC_NONE;
            for (int s = 0; s < NUM_SETS; s++) begin
                victim[s] <= '0;
            end
        end else begin
            // round robin, step past the way that was just used
            if (readEn && victim[setIdx] == hitWay) begin
                victim[setIdx] <= victim[setIdx] + 1'b1;
            end

            case (state)
                CLEAN: begin
                    for (int w = 0; w < ASSOC; w++) begin
                        tagTable[cleanIdx][w].valid <= 1'b0;
                    end
                    if (cleanIdx == SET_BITS'(NUM_SETS - 1)) begin
                        state <= IDLE;
                    end
                    cleanIdx <= cleanIdx + 1'b1;
                end
                LOAD_RQ: begin
                    if (memc.busy) begin
                        memc.cmd <= MEMC_NONE;
                        state <= LOAD_ACTIVE;
                    end
                end
                LOAD_ACTIVE: begin
                    if (!memc.busy) begin
                        tagTable[loadSet][loadWay].valid <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: begin
                    if (fetchValid && !hit) begin
                        memc.cmd <= MEMC_FILL;
                        memc.lineAddr <= fetchPc[31:CLSIZE_E];
                        memc.dataBase <= {victim[setIdx], setIdx};
                        loadSet <= setIdx;
                        loadWay <= victim[setIdx];
                        // claim the victim way now, it turns valid after the fill
                        tagTable[setIdx][victim[setIdx]] <= '{tag: pcTag, valid: 1'b0};
                        state <= LOAD_RQ;
                    end
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        memc.cmd == MEMC_FILL |-> state == LOAD_RQ);

    assert property (@(posedge clk) disable iff (rst)
        !(readEn && fetchStall));

endmodule

//--- hw/iCacheTop.sv
`timescale 1ns/1ps

module iCacheTop
    import iCachePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        fetchValid,
    input  logic [31:0] fetchPc,
    output logic        fetchStall,
    output logic        instrValid,
    output logic [31:0] instr,
    output logic        arvalid,
    input  logic        arready,
    output logic [31:0] araddr,
    output logic [2:0]  arprot,
    input  logic        rvalid,
    output logic        rready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp
);

    logic [DATA_ADDR_BITS-1:0] lookupAddr;
    logic                      readEn;
    logic                      wrEn;
    logic [DATA_ADDR_BITS-1:0] wrAddr;
    logic [31:0]               wrData;

    memcIf memcBus ();

    iCacheTable tableInst (
        .clk        (clk),
        .rst        (rst),
        .fetchValid (fetchValid),
        .fetchPc    (fetchPc),
        .fetchStall (fetchStall),
        .lookupAddr (lookupAddr),
        .readEn     (readEn),
        .memc       (memcBus.client)
    );

    lineFillCtrl fillInst (
        .clk     (clk),
        .rst     (rst),
        .memc    (memcBus.server),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (wrData),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arprot  (arprot),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    iCacheData dataInst (
        .clk        (clk),
        .rst        (rst),
        .readEn     (readEn),
        .lookupAddr (lookupAddr),
        .wrEn       (wrEn),
        .wrAddr     (wrAddr),
        .wrData     (wrData),
        .instrValid (instrValid),
        .instr      (instr)
    );

    // once a fill completes, a lookup of that same line hits right away
    assert property (@(posedge clk) disable iff (rst)
        $fell(memcBus.busy) |=> !fetchStall
            || TagEntry'{fetchPc[31 -: TAG_BITS], fetchValid}
               != TagEntry'{memcBus.lineAddr[31-CLSIZE_E -: TAG_BITS], 1'b1}
            || fetchPc[CLSIZE_E +: SET_BITS] != memcBus.lineAddr[SET_BITS-1:0]);

endmodule

//--- hw/lineFillCtrl.sv
`timescale 1ns/1ps

module lineFillCtrl
    import iCachePkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    memcIf.server                     memc,
    output logic                      wrEn,
    output logic [DATA_ADDR_BITS-1:0] wrAddr,
    output logic [31:0]               wrData,
    output logic                      arvalid,
    input  logic                      arready,
    output logic [31:0]               araddr,
    output logic [2:0]                arprot,
    input  logic                      rvalid,
    output logic                      rready,
    input  logic [31:0]               rdata,
    input  logic [1:0]                rresp
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        RESP,
        FINISH
    } FillState;

    FillState state;

    logic [31-CLSIZE_E:0]         lineAddr;
    logic [WAY_BITS+SET_BITS-1:0] lineBase;
    logic [CLSIZE_E-3:0]          wordCnt;
    logic [CLSIZE_E-3:0]          nextWord;
    logic                         lastWord;

    assign nextWord = wordCnt + 1'b1;
    assign lastWord = int'(wordCnt) == WORDS_PER_LINE - 1;

    // unprivileged secure instruction access
    assign arprot = 3'b100;

    always_ff @(posedge clk) begin
        wrEn <= 1'b0;
        if (rst) begin
            state <= IDLE;
            memc.busy <= 1'b0;
            arvalid <= 1'b0;
            rready <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (memc.cmd == MEMC_FILL) begin
                        lineAddr <= memc.lineAddr;
                        lineBase <= memc.dataBase;
                        wordCnt <= '0;
                        araddr <= {memc.lineAddr, {CLSIZE_E{1'b0}}};
                        arvalid <= 1'b1;
                        memc.busy <= 1'b1;
                        state <= ADDR;
                    end
                end
                ADDR: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        rready <= 1'b1;
                        state <= RESP;
                    end
                end
                RESP: begin
                    if (rvalid) begin
                        rready <= 1'b0;
                        wrEn <= 1'b1;
                        wrAddr <= {lineBase, wordCnt};
                        wrData <= rdata;
                        wordCnt <= nextWord;
                        if (lastWord) begin
                            state <= FINISH;
                        end else begin
                            araddr <= {lineAddr, nextWord, 2'b00};
                            arvalid <= 1'b1;
                            state <= ADDR;
                        end
                    end
                end
                default: begin
                    // last word lands in the array on this edge
                    memc.busy <= 1'b0;
                    state <= IDLE;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr));

    // a slave error would leave a bad word in the line
    assert property (@(posedge clk) disable iff (rst)
        rvalid && rready |-> rresp == 2'b00);

endmodule

//--- hw/memcIf.sv
`timescale 1ns/1ps

interface memcIf
    import iCachePkg::*;
();

    MemcCmd cmd;

    // external line address, pc without the line offset
    logic [31-CLSIZE_E:0] lineAddr;

    // {way, set} part of the data array address
    logic [WAY_BITS+SET_BITS-1:0] dataBase;

    logic busy;

    // tag table side
    modport client (
        output cmd,
        output lineAddr,
        output dataBase,
        input  busy
    );

    // fill controller side
    modport server (
        input  cmd,
        input  lineAddr,
        input  dataBase,
        output busy
    );

endinterface

//--- run.sh
#!/bin/sh
# build the instruction cache testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module iCacheTb -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/ViCacheTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Everything OK$"; then
    exit 0
else
    exit 1
fi

//--- sim/axiMemModel.sv
`timescale 1ns/1ps

module axiMemModel (
    input  logic        clk,
    input  logic        rst,
    input  logic        arvalid,
    output logic        arready,
    input  logic [31:0] araddr,
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp
);

    localparam logic [31:0] DATA_KEY = 32'hC0DE0000;
    localparam int MAX_DELAY = 3;

    // every word reads back as its byte address scrambled by a fixed key
    function automatic logic [31:0] wordAt(logic [31:0] addr);
        return addr ^ DATA_KEY;
    endfunction

    // outputs change a little after the rising edge
    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic waitRandom();
        int delay;
        delay = $urandom % (MAX_DELAY + 1);
        repeat (delay) begin
            nextCycle();
        end
    endtask

    initial begin
        logic [31:0] addr;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rresp = 2'b00;
        forever begin
            nextCycle();
            if (!rst && arvalid) begin
                waitRandom();
                arready = 1'b1;
                addr = araddr;
                // address handshake on the coming edge
                nextCycle();
                arready = 1'b0;
                waitRandom();
                rvalid = 1'b1;
                rdata = wordAt(addr);
                rresp = 2'b00;
                while (!rready) begin
                    nextCycle();
                end
                nextCycle();
                rvalid = 1'b0;
                rdata = '0;
            end
        end
    end

endmodule

//--- sim/fetchTrace.txt
# columns: fetch pc (hex), expected hit in the first cycle (1 or 0), expected instruction (hex)
# data words are the byte address xor c0de0000
00001080 0 C0DE1080
00001084 1 C0DE1084
000010BC 1 C0DE10BC
000010A0 1 C0DE10A0
00002088 0 C0DE2088
0000208C 1 C0DE208C
00001090 1 C0DE1090
000030B0 0 C0DE30B0
00001080 1 C0DE1080
00002080 0 C0DE2080
000030B0 0 C0DE30B0
00002084 1 C0DE2084
00001080 0 C0DE1080
000030BC 0 C0DE30BC
00001088 1 C0DE1088
000030A4 1 C0DE30A4
80000100 0 40DE0100
8000013C 1 40DE013C
00001FC0 0 C0DE1FC0
00001FFC 1 C0DE1FFC
80000104 1 40DE0104
00000040 0 C0DE0040
0000007C 1 C0DE007C
000010B8 1 C0DE10B8
00002090 0 C0DE2090
000030A0 0 C0DE30A0

//--- sim/iCacheTb.sv
`timescale 1ns/1ps

module iCacheTb;

    localparam string TRACE_FILE = "sim/fetchTrace.txt";
    localparam int CYCLES_PER_FETCH = 200;
    localparam int STALL_LIMIT = 400;

    // AXI protection bits of an unprivileged secure instruction fetch
    localparam logic [2:0] FETCH_PROT = 3'b100;

    logic        clk;
    logic        rst;
    logic        fetchValid;
    logic [31:0] fetchPc;
    logic        fetchStall;
    logic        instrValid;
    logic [31:0] instr;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic [2:0]  arprot;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;

    logic [31:0] tracePc [$];
    bit          traceHit [$];
    logic [31:0] traceInstr [$];
    bit          traceLoaded = 1'b0;

    iCacheTop dut_i (
        .clk        (clk),
        .rst        (rst),
        .fetchValid (fetchValid),
        .fetchPc    (fetchPc),
        .fetchStall (fetchStall),
        .instrValid (instrValid),
        .instr      (instr),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .arprot     (arprot),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp)
    );

    axiMemModel memModel (
        .clk     (clk),
        .rst     (rst),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic stopWithFailure();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            stopWithFailure();
        end
    endtask

    // every read request of the fill is an instruction fetch
    always @(negedge clk) begin
        if (!rst && arvalid) begin
            checkValue("arprot", 32'(FETCH_PROT), 32'(arprot));
        end
    end

    // lines starting with # are comments
    task automatic loadTrace();
        int          fd;
        int          fields;
        int          hitFlag;
        string       line;
        logic [31:0] pc;
        logic [31:0] word;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("could not open the trace file %s", TRACE_FILE);
            stopWithFailure();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%h %d %h", pc, hitFlag, word);
            if (fields == 3) begin
                tracePc.push_back(pc);
                traceHit.push_back(hitFlag != 0);
                traceInstr.push_back(word);
            end
        end
        $fclose(fd);
        if (tracePc.size() == 0) begin
            $display("the trace file holds no fetch entries");
            stopWithFailure();
        end
    endtask

    task automatic runFetch(logic [31:0] pc, bit expHit, logic [31:0] expInstr);
        int stallCycles;
        @(posedge clk);
        #1;
        checkValue("instrValid", 32'(1'b0), 32'(instrValid));
        fetchValid = 1'b1;
        fetchPc = pc;
        #1;
        checkValue("fetchStall", 32'(!expHit), 32'(fetchStall));
        stallCycles = 0;
        while (fetchStall) begin
            if (stallCycles == STALL_LIMIT) begin
                $display("fetch of pc %h stayed stalled for %0d cycles", pc, STALL_LIMIT);
                stopWithFailure();
            end
            @(posedge clk);
            #2;
            checkValue("instrValid", 32'(1'b0), 32'(instrValid));
            stallCycles++;
        end
        // the fetch is accepted on this edge and its instruction follows one cycle later
        @(posedge clk);
        #1;
        fetchValid = 1'b0;
        checkValue("instrValid", 32'(1'b1), 32'(instrValid));
        checkValue("instr", expInstr, instr);
    endtask

    initial begin
        int gap;
        void'($urandom(32'hb632cd8e));
        rst = 1'b1;
        fetchValid = 1'b0;
        fetchPc = '0;
        loadTrace();
        traceLoaded = 1'b1;
        repeat (8) begin
            @(posedge clk);
        end
        #1;
        rst = 1'b0;
        foreach (tracePc[i]) begin
            runFetch(tracePc[i], traceHit[i], traceInstr[i]);
            gap = $urandom % 3;
            repeat (gap) begin
                @(posedge clk);
                #1;
                checkValue("instrValid", 32'(1'b0), 32'(instrValid));
            end
        end
        $display("Everything OK");
        $finish;
    end

    initial begin
        wait (traceLoaded);
        repeat (CYCLES_PER_FETCH * tracePc.size() + 100) begin
            @(posedge clk);
        end
        $display("timeout, the fetch trace did not finish in time");
        stopWithFailure();
    end

endmodule

//--- verilog.f
hw/iCachePkg.sv
hw/memcIf.sv
hw/iCacheTable.sv
hw/lineFillCtrl.sv
hw/iCacheData.sv
hw/iCacheTop.sv
sim/axiMemModel.sv
sim/iCacheTb.sv
